//--- logic/dcache_pkg.sv
package dcache_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////////////

   // One row is a quad word
   localparam int WORD_W = 32;
   localparam int LINE_W = 4 * WORD_W;

   ////////////////////////////////////////////////////////////////////////////
   // Enums
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      CMD_NONE  = 2'd0,
      CMD_CLEAN = 2'd1,
      CMD_FILL  = 2'd2
   } dcache_cmd_e;

   typedef enum logic [2:0] {
      S_IDLE,
      S_SCAN,
      S_WB,
      S_REQ,
      S_WAIT
   } seq_state_e;

   ////////////////////////////////////////////////////////////////////////////
   // Structs
   ////////////////////////////////////////////////////////////////////////////

   // CPU side access, wr_addr is a word address
   typedef struct packed {
      logic              rd_en;
      logic [7:0]        rd_row;
      logic [7:0]        wr_addr;
      logic [WORD_W-1:0] wr_data;
      logic [3:0]        wr_be;
   } cpu_req_s;

   // w0 sits in the low bits
   typedef struct packed {
      logic [WORD_W-1:0] w3;
      logic [WORD_W-1:0] w2;
      logic [WORD_W-1:0] w1;
      logic [WORD_W-1:0] w0;
   } line_s;

endpackage

//--- logic/dcache_word_bank.sv
module dcache_word_bank #(
   parameter int ADDR_WIDTH = 5
) (
   input  logic                           clk_i,
   input  logic                           rd_en_i,
   input  logic [ADDR_WIDTH-3:0]          rd_row_i,
   input  logic [ADDR_WIDTH-3:0]          wr_row_i,
   input  logic [dcache_pkg::WORD_W-1:0]  wr_data_i,
   input  logic [3:0]                     wr_be_i,
   input  logic                           load_en_i,
   input  logic [ADDR_WIDTH-3:0]          load_row_i,
   input  logic [dcache_pkg::WORD_W-1:0]  load_word_i,
   output logic [dcache_pkg::WORD_W-1:0]  rd_word_o
);
   import dcache_pkg::*;

   localparam int ROWS = 2 ** (ADDR_WIDTH - 2);

   // One word per row
   logic [WORD_W-1:0] mem_q [ROWS];

   ////////////////////////////////////////////////////////////////////////////
   // Write port
   ////////////////////////////////////////////////////////////////////////////

   // Line load takes the port over a CPU write
   always_ff @(posedge clk_i) begin
      if (load_en_i) begin
         mem_q[load_row_i] <= load_word_i;
      end else begin
         for (int b = 0; b < 4; b++) begin
            if (wr_be_i[b]) begin
               mem_q[wr_row_i][8*b +: 8] <= wr_data_i[8*b +: 8];
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read port
   ////////////////////////////////////////////////////////////////////////////

   // Registered read, holds the last word when idle
   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_word_o <= mem_q[rd_row_i];
      end
   end

endmodule

//--- logic/dcache_qword_block.sv
module dcache_qword_block #(
   parameter int ADDR_WIDTH = 5
) (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            rd_en_i,
   input  logic [ADDR_WIDTH-3:0]           rd_row_i,
   input  dcache_pkg::cpu_req_s            cpu_wr_i,
   input  logic                            load_en_i,
   input  logic [ADDR_WIDTH-3:0]           load_row_i,
   input  dcache_pkg::line_s               load_line_i,
   input  logic                            clean_en_i,
   input  logic [ADDR_WIDTH-3:0]           clean_row_i,
   output dcache_pkg::line_s               rd_line_o,
   output logic [2**(ADDR_WIDTH-2)-1:0]    dirty_o
);
   import dcache_pkg::*;

   localparam int ROW_W = ADDR_WIDTH - 2;
   localparam int ROWS  = 2 ** ROW_W;

   logic [ROWS-1:0]   dirty_q;
   logic [ROW_W-1:0]  wr_row;
   logic [1:0]        wr_sel;
   logic              wr_any;
   logic              load_gated;
   logic [LINE_W-1:0] load_flat;
   logic [LINE_W-1:0] rd_flat;

   // Word address split into row and word select
   assign wr_row = cpu_wr_i.wr_addr[ADDR_WIDTH-1:2];
   assign wr_sel = cpu_wr_i.wr_addr[1:0];
   assign wr_any = |cpu_wr_i.wr_be;

   // Clean rows must never be overwritten by a fill
   assign load_gated = load_en_i & dirty_q[load_row_i];

   assign load_flat = load_line_i;
   assign rd_line_o = rd_flat;
   assign dirty_o   = dirty_q;

   ////////////////////////////////////////////////////////////////////////////
   // Word banks, bank i holds word i of every row
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < 4; i++) begin : g_bank
      logic [3:0] bank_be;

      assign bank_be = (wr_sel == 2'(i)) ? cpu_wr_i.wr_be : 4'b0000;

      dcache_word_bank #(
         .ADDR_WIDTH (ADDR_WIDTH)
      ) i_dcache_word_bank (
         .clk_i       (clk_i),
         .rd_en_i     (rd_en_i),
         .rd_row_i    (rd_row_i),
         .wr_row_i    (wr_row),
         .wr_data_i   (cpu_wr_i.wr_data),
         .wr_be_i     (bank_be),
         .load_en_i   (load_gated),
         .load_row_i  (load_row_i),
         .load_word_i (load_flat[i*WORD_W +: WORD_W]),
         .rd_word_o   (rd_flat[i*WORD_W +: WORD_W])
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // Dirty bits
   ////////////////////////////////////////////////////////////////////////////

   // All rows start dirty so the first fill loads everything
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dirty_q <= '1;
      end else begin
         if (wr_any) begin
            dirty_q[wr_row] <= 1'b1;
         end
         if (load_gated) begin
            dirty_q[load_row_i] <= 1'b0;
         end
         // Data stays, only the flag drops
         if (clean_en_i) begin
            dirty_q[clean_row_i] <= 1'b0;
         end
      end
   end

endmodule

//--- logic/dcache_sync_seq.sv
module dcache_sync_seq #(
   parameter int ADDR_WIDTH = 5
) (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  dcache_pkg::dcache_cmd_e       cmd_i,
   input  logic [2**(ADDR_WIDTH-2)-1:0]  dirty_i,
   input  dcache_pkg::line_s             rd_line_i,
   input  dcache_pkg::line_s             mem_line_i,
   input  logic                          mem_valid_i,
   output logic                          busy_o,
   output logic                          scan_rd_en_o,
   output logic [ADDR_WIDTH-3:0]         scan_row_o,
   output logic                          load_en_o,
   output logic [ADDR_WIDTH-3:0]         load_row_o,
   output dcache_pkg::line_s             load_line_o,
   output logic                          clean_en_o,
   output logic [ADDR_WIDTH-3:0]         clean_row_o,
   output logic                          mem_rd_o,
   output logic [ADDR_WIDTH-3:0]         mem_row_o,
   output logic                          mem_wb_o,
   output logic [ADDR_WIDTH-3:0]         mem_wb_row_o,
   output dcache_pkg::line_s             mem_wb_line_o
);
   import dcache_pkg::*;

   localparam int ROW_W = ADDR_WIDTH - 2;
   localparam int ROWS  = 2 ** ROW_W;
   localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(ROWS - 1);

   seq_state_e  state_q, state_d;
   dcache_cmd_e cmd_q;
   logic [ROW_W-1:0] row_q;
   logic cmd_ok;
   logic row_dirty;
   logic row_done;

   assign cmd_ok    = (cmd_i == CMD_CLEAN) || (cmd_i == CMD_FILL);
   assign row_dirty = dirty_i[row_q];

   // Current row is finished this cycle
   assign row_done = ((state_q == S_SCAN) && !row_dirty) ||
                     (state_q == S_WB) ||
                     ((state_q == S_WAIT) && mem_valid_i);

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: if (cmd_ok) state_d = S_SCAN;
         S_SCAN: begin
            if (row_dirty) begin
               state_d = (cmd_q == CMD_CLEAN) ? S_WB : S_REQ;
            end
         end
         S_REQ:   state_d = S_WAIT;
         default: state_d = state_q;
      endcase
      if (row_done) begin
         state_d = (row_q == LAST_ROW) ? S_IDLE : S_SCAN;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= S_IDLE;
         cmd_q   <= CMD_NONE;
         row_q   <= '0;
      end else begin
         state_q <= state_d;
         if ((state_q == S_IDLE) && cmd_ok) begin
            cmd_q <= cmd_i;
            row_q <= '0;
         end else if (row_done) begin
            row_q <= row_q + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Outputs decoded from state
   ////////////////////////////////////////////////////////////////////////////

   assign busy_o       = (state_q != S_IDLE);
   // Dirty row read for write-back, data is back in S_WB
   assign scan_rd_en_o = (state_q == S_SCAN) && row_dirty && (cmd_q == CMD_CLEAN);
   assign scan_row_o   = row_q;

   assign mem_wb_o      = (state_q == S_WB);
   assign mem_wb_row_o  = row_q;
   assign mem_wb_line_o = rd_line_i;
   assign clean_en_o    = (state_q == S_WB);
   assign clean_row_o   = row_q;

   assign mem_rd_o    = (state_q == S_REQ);
   assign mem_row_o   = row_q;
   assign load_en_o   = (state_q == S_WAIT) && mem_valid_i;
   assign load_row_o  = row_q;
   assign load_line_o = mem_line_i;

endmodule

//--- logic/dcache_line_top.sv
module dcache_line_top #(
   parameter int ADDR_WIDTH = 5
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  dcache_pkg::cpu_req_s     cpu_req_i,
   output dcache_pkg::line_s        rd_line_o,
   input  dcache_pkg::dcache_cmd_e  cmd_i,
   output logic                     busy_o,
   output logic                     mem_rd_o,
   output logic [ADDR_WIDTH-3:0]    mem_row_o,
   input  dcache_pkg::line_s        mem_line_i,
   input  logic                     mem_valid_i,
   output logic                     mem_wb_o,
   output logic [ADDR_WIDTH-3:0]    mem_wb_row_o,
   output dcache_pkg::line_s        mem_wb_line_o
);
   import dcache_pkg::*;

   localparam int ROW_W = ADDR_WIDTH - 2;
   localparam int ROWS  = 2 ** ROW_W;

   logic             scan_rd_en;
   logic [ROW_W-1:0] scan_row;
   logic             blk_rd_en;
   logic [ROW_W-1:0] blk_rd_row;
   logic             load_en;
   logic [ROW_W-1:0] load_row;
   line_s            load_line;
   logic             clean_en;
   logic [ROW_W-1:0] clean_row;
   logic [ROWS-1:0]  dirty;

   // Sequencer owns the read port while busy
   assign blk_rd_en  = busy_o ? scan_rd_en : cpu_req_i.rd_en;
   assign blk_rd_row = busy_o ? scan_row : cpu_req_i.rd_row[ROW_W-1:0];

   dcache_qword_block #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) i_dcache_qword_block (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .rd_en_i     (blk_rd_en),
      .rd_row_i    (blk_rd_row),
      .cpu_wr_i    (cpu_req_i),
      .load_en_i   (load_en),
      .load_row_i  (load_row),
      .load_line_i (load_line),
      .clean_en_i  (clean_en),
      .clean_row_i (clean_row),
      .rd_line_o   (rd_line_o),
      .dirty_o     (dirty)
   );

   dcache_sync_seq #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) i_dcache_sync_seq (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .cmd_i         (cmd_i),
      .dirty_i       (dirty),
      .rd_line_i     (rd_line_o),
      .mem_line_i    (mem_line_i),
      .mem_valid_i   (mem_valid_i),
      .busy_o        (busy_o),
      .scan_rd_en_o  (scan_rd_en),
      .scan_row_o    (scan_row),
      .load_en_o     (load_en),
      .load_row_o    (load_row),
      .load_line_o   (load_line),
      .clean_en_o    (clean_en),
      .clean_row_o   (clean_row),
      .mem_rd_o      (mem_rd_o),
      .mem_row_o     (mem_row_o),
      .mem_wb_o      (mem_wb_o),
      .mem_wb_row_o  (mem_wb_row_o),
      .mem_wb_line_o (mem_wb_line_o)
   );

endmodule

//--- dv/dcache_line_sva.sv
module dcache_line_sva #(
   parameter int ADDR_WIDTH = 5
) (
   input logic                     clk_i,
   input logic                     rst_i,
   input dcache_pkg::cpu_req_s     cpu_req_i,
   input dcache_pkg::line_s        rd_line_i,
   input dcache_pkg::dcache_cmd_e  cmd_i,
   input logic                     busy_i,
   input logic                     mem_rd_i,
   input logic [ADDR_WIDTH-3:0]    mem_row_i,
   input logic                     mem_valid_i,
   input logic                     mem_wb_i,
   input logic [ADDR_WIDTH-3:0]    mem_wb_row_i,
   input dcache_pkg::line_s        mem_wb_line_i
);
   timeunit 1ns;
   timeprecision 100ps;

   import dcache_pkg::*;

   localparam int ROW_W = ADDR_WIDTH - 2;
   localparam int ROWS  = 2 ** ROW_W;

   int unsigned      fail_cnt = 0;
   line_s            exp_rd_line;
   line_s            exp_wb_line;
   logic [ROWS-1:0]  exp_dirty;
   logic             accept;
   logic             req;
   logic [ROW_W-1:0] req_row;
   dcache_cmd_e      cmd_q;
   logic [ROWS-1:0]  req_seen_q;
   logic [ROW_W-1:0] last_row_q;
   logic             any_q;
   logic             pend_q;

   // Expected values come from the testbench copy
   assign exp_rd_line = dcache_line_tb.shadow_line[cpu_req_i.rd_row[ROW_W-1:0]];
   assign exp_wb_line = dcache_line_tb.shadow_line[mem_wb_row_i];
   assign exp_dirty   = dcache_line_tb.shadow_dirty;

   assign accept  = !busy_i && (cmd_i != CMD_NONE);
   assign req     = mem_rd_i || mem_wb_i;
   assign req_row = mem_rd_i ? mem_row_i : mem_wb_row_i;

   // Rows requested in the current command
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cmd_q      <= CMD_NONE;
         req_seen_q <= '0;
         last_row_q <= '0;
         any_q      <= 1'b0;
         pend_q     <= 1'b0;
      end else begin
         if (accept) begin
            cmd_q      <= cmd_i;
            req_seen_q <= '0;
            any_q      <= 1'b0;
         end else if (req) begin
            req_seen_q[req_row] <= 1'b1;
            last_row_q          <= req_row;
            any_q               <= 1'b1;
         end
         if (mem_rd_i) begin
            pend_q <= 1'b1;
         end else if (mem_valid_i) begin
            pend_q <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Properties
   ////////////////////////////////////////////////////////////////////////////

   read_data_a : assert property (@(posedge clk_i) disable iff (rst_i)
      cpu_req_i.rd_en && !busy_i |=> rd_line_i == $past(exp_rd_line))
   else begin
      fail_cnt++;
      $error("error at %0t: read line differs from the expected line", $time);
   end

   wb_data_a : assert property (@(posedge clk_i) disable iff (rst_i)
      mem_wb_i |-> (cmd_q == CMD_CLEAN) && (mem_wb_line_i == exp_wb_line))
   else begin
      fail_cnt++;
      $error("error at %0t: write-back of row %0d has the wrong line", $time, mem_wb_row_i);
   end

   // One outstanding read at a time
   mem_rd_a : assert property (@(posedge clk_i) disable iff (rst_i)
      mem_rd_i |-> (cmd_q == CMD_FILL) && !pend_q)
   else begin
      fail_cnt++;
      $error("error at %0t: memory read outside a fill or while one is pending", $time);
   end

   row_order_a : assert property (@(posedge clk_i) disable iff (rst_i)
      req && any_q |-> req_row > last_row_q)
   else begin
      fail_cnt++;
      $error("error at %0t: memory request for row %0d out of order", $time, req_row);
   end

   idle_quiet_a : assert property (@(posedge clk_i) disable iff (rst_i)
      !busy_i |-> !mem_rd_i && !mem_wb_i)
   else begin
      fail_cnt++;
      $error("error at %0t: memory strobe while not busy", $time);
   end

   busy_rise_a : assert property (@(posedge clk_i) disable iff (rst_i)
      accept |=> busy_i)
   else begin
      fail_cnt++;
      $error("error at %0t: busy did not rise after a command", $time);
   end

   // Exactly the dirty rows were serviced
   busy_done_a : assert property (@(posedge clk_i) disable iff (rst_i)
      $fell(busy_i) |-> req_seen_q == $past(exp_dirty))
   else begin
      fail_cnt++;
      $error("error at %0t: serviced rows %b, expected %b", $time, req_seen_q,
             $past(exp_dirty));
   end

endmodule

//--- dv/dcache_line_tb.sv
module dcache_line_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import dcache_pkg::*;

   localparam int ADDR_WIDTH = 5;
   localparam int ROW_W      = ADDR_WIDTH - 2;
   localparam int ROWS       = 2 ** ROW_W;
   // Roughly four times 8 rows x 6 cycles x 10 commands
   localparam int MAX_CYCLES = 4 * ROWS * 6 * 10 + 80;
   localparam logic [31:0] LFSR_SEED = 32'hdaa1_adeb;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   logic             clk;
   logic             rst;
   cpu_req_s         cpu_req;
   line_s            rd_line;
   dcache_cmd_e      cmd;
   logic             busy;
   logic             mem_rd;
   logic [ROW_W-1:0] mem_row;
   line_s            mem_line = '0;
   logic             mem_valid = 1'b0;
   logic             mem_wb;
   logic [ROW_W-1:0] mem_wb_row;
   line_s            mem_wb_line;

   logic [31:0]      lfsr_state;
   int unsigned      cycle_cnt = 0;
   int unsigned      sva_fails;
   line_s [ROWS-1:0] mem_model;
   // Expected cache state, the bound checker reads it
   line_s [ROWS-1:0] shadow_line;
   logic [ROWS-1:0]  shadow_dirty;

   dcache_line_top i_dcache_line_top (
      .clk_i         (clk),
      .rst_i         (rst),
      .cpu_req_i     (cpu_req),
      .rd_line_o     (rd_line),
      .cmd_i         (cmd),
      .busy_o        (busy),
      .mem_rd_o      (mem_rd),
      .mem_row_o     (mem_row),
      .mem_line_i    (mem_line),
      .mem_valid_i   (mem_valid),
      .mem_wb_o      (mem_wb),
      .mem_wb_row_o  (mem_wb_row),
      .mem_wb_line_o (mem_wb_line)
   );

   bind dcache_line_top dcache_line_sva #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) i_dcache_line_sva (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .cpu_req_i     (cpu_req_i),
      .rd_line_i     (rd_line_o),
      .cmd_i         (cmd_i),
      .busy_i        (busy_o),
      .mem_rd_i      (mem_rd_o),
      .mem_row_i     (mem_row_o),
      .mem_valid_i   (mem_valid_i),
      .mem_wb_i      (mem_wb_o),
      .mem_wb_row_i  (mem_wb_row_o),
      .mem_wb_line_i (mem_wb_line_o)
   );

   assign sva_fails = i_dcache_line_top.i_dcache_line_sva.fail_cnt;

   always #50 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Random numbers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic lfsr_step();
      logic out_bit;
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
         lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      return out_bit;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_step()};
      end
      return r;
   endfunction

   function automatic line_s rand_line();
      line_s l;
      l.w0 = rand_bits(32);
      l.w1 = rand_bits(32);
      l.w2 = rand_bits(32);
      l.w3 = rand_bits(32);
      return l;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Waits for the sequence to end, then applies the command to the expected state
   task automatic run_command(input dcache_cmd_e c);
      cmd = c;
      next_cycle();
      cmd = CMD_NONE;
      while (busy) begin
         next_cycle();
      end
      for (int r = 0; r < ROWS; r++) begin
         if (shadow_dirty[r] && (c == CMD_CLEAN)) begin
            mem_model[r] = shadow_line[r];
         end else if (shadow_dirty[r]) begin
            shadow_line[r] = mem_model[r];
         end
      end
      shadow_dirty = '0;
   endtask

   task automatic write_word(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
      logic [LINE_W-1:0] flat;
      int                row;
      int                sel;
      row  = int'(addr[ADDR_WIDTH-1:2]);
      sel  = int'(addr[1:0]);
      flat = shadow_line[row];
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            flat[sel*WORD_W + 8*b +: 8] = data[8*b +: 8];
         end
      end
      shadow_line[row] = flat;
      if (be != 4'b0000) begin
         shadow_dirty[row] = 1'b1;
      end
      cpu_req.wr_addr = addr;
      cpu_req.wr_data = data;
      cpu_req.wr_be   = be;
      next_cycle();
      cpu_req.wr_be   = 4'b0000;
   endtask

   task automatic read_row(input int row);
      cpu_req.rd_en  = 1'b1;
      cpu_req.rd_row = 8'(row);
      next_cycle();
      cpu_req.rd_en  = 1'b0;
   endtask

   task automatic read_all();
      for (int r = 0; r < ROWS; r++) begin
         read_row(r);
      end
   endtask

   // Each write is read back right away
   task automatic random_writes(input int count);
      logic [7:0] addr;
      logic [3:0] be;
      for (int i = 0; i < count; i++) begin
         addr = 8'(rand_bits(ADDR_WIDTH));
         be   = 4'(rand_bits(4));
         if (be == 4'b0000) begin
            be = 4'b1111;
         end
         write_word(addr, rand_bits(32), be);
         read_row(int'(addr[ADDR_WIDTH-1:2]));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Memory model, answers each read after 1 to 4 cycles
   ////////////////////////////////////////////////////////////////////////////

   always begin : mem_responder
      int               wait_cycles;
      logic [ROW_W-1:0] row;
      @(posedge clk);
      #1;
      mem_valid = 1'b0;
      if (mem_rd) begin
         row         = mem_row;
         wait_cycles = 1 + int'(rand_bits(2));
         repeat (wait_cycles) @(posedge clk);
         #1;
         mem_line  = mem_model[row];
         mem_valid = 1'b1;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Simulation FAILED");
         $fatal(1, "timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
      end
   end

   // Stop at the first assertion failure
   always begin
      @(posedge clk);
      #2;
      if (sva_fails != 0) begin
         $display("Simulation FAILED");
         $fatal(1, "a checker assertion failed before %0t", $time);
      end
   end

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      cpu_req      = '0;
      cmd          = CMD_NONE;
      lfsr_state   = LFSR_SEED;
      shadow_line  = '0;
      shadow_dirty = '1;
      for (int r = 0; r < ROWS; r++) begin
         mem_model[r] = rand_line();
      end
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      next_cycle();

      // Every row is dirty after reset
      run_command(CMD_FILL);
      read_all();
      random_writes(6);
      run_command(CMD_CLEAN);
      run_command(CMD_CLEAN);
      // Nothing dirty, so no memory reads
      run_command(CMD_FILL);
      read_all();
      random_writes(4);
      run_command(CMD_FILL);
      read_all();
      random_writes(8);
      run_command(CMD_CLEAN);
      read_all();

      repeat (3) next_cycle();
      if (sva_fails == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("Simulation FAILED");
         $fatal(1, "%0d checker assertions failed", sva_fails);
      end
   end

endmodule

//--- compile.f
logic/dcache_pkg.sv
logic/dcache_word_bank.sv
logic/dcache_qword_block.sv
logic/dcache_sync_seq.sv
logic/dcache_line_top.sv
dv/dcache_line_sva.sv
dv/dcache_line_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the cache line testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
   --top-module dcache_line_tb -Mdir "$OBJ" -f compile.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/Vdcache_line_tb" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation run returned status $status"
   exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
   exit 1
fi
exit 0
